// File: audio_pkg.sv
package audio_pkg;

  // ----------------------------------------
  // word widths
  // ----------------------------------------
  localparam int SAMPLE_W  = 16;  // pcm sample from the codec
  localparam int COEF_W    = 16;  // tap weight
  localparam int COEF_FRAC = 15;  // q1.15 weights
  localparam int ACC_W     = 40;  // 16 taps without wrap

  // ----------------------------------------
  // data types
  // ----------------------------------------
  typedef logic signed [SAMPLE_W-1:0] sample_t;  // one audio word
  typedef logic signed [COEF_W-1:0]   coef_t;    // one tap weight

  // clamp limits of the sample range
  localparam sample_t SAMPLE_MAX = 16'sh7FFF;  // most positive
  localparam sample_t SAMPLE_MIN = 16'sh8000;  // most negative

  // ----------------------------------------
  // reset values of the coefficient bank
  // ----------------------------------------
  localparam coef_t COEF_UNITY = 16'sh7FFF;  // tap 0, near 1.0 in q1.15
  localparam coef_t COEF_ZERO  = 16'sh0000;  // all other taps

endpackage

// File: sample_fifo.sv
`timescale 1ns/10ps

module sample_fifo #(
  parameter int DEPTH = 16
) (
  input  logic              clk_50M,
  input  logic              rst_n,
  input  logic              clear,    // sync flush
  input  logic              wr,
  input  audio_pkg::sample_t wr_data,
  input  logic              rd,       // pop head
  output audio_pkg::sample_t rd_data,
  output logic              full,
  output logic              empty
);

  import audio_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  sample_t          mem [DEPTH];  // storage array
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;        // words held
  logic             wr_ok;
  logic             rd_ok;

  assign wr_ok = wr && !full && !clear;   // drop write when full
  assign rd_ok = rd && !empty && !clear;  // drop read when empty

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign rd_data = mem[rd_ptr];           // fall-through head

  // ----------------------------------------
  // pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge clk_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (clear)
    begin
      wr_ptr <= '0;                       // flush
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_ok)
      begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap at depth
      end
      if (rd_ok)
      begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;   // push only
        2'b01:   count <= count - 1'b1;   // pop only
        default: count <= count;          // both or none
      endcase
    end
  end

  // storage write
  always_ff @(posedge clk_50M)
  begin
    if (wr_ok)
    begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

// File: burst_read_ctrl.sv
`timescale 1ns/10ps

module burst_read_ctrl #(
  parameter int CLK_DIV = 10
) (
  input  logic clk_50M,
  input  logic rst_n,
  input  logic enable,      // low holds everything idle
  input  logic fifo_full,
  input  logic fifo_empty,
  output logic pop          // one read per pace strobe
);

  localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  logic [CNT_W-1:0] pace_cnt;  // sample-rate divider
  logic             pace_stb;  // one pulse per CLK_DIV cycles
  logic             burst;     // fill-then-drain read window

  // ----------------------------------------
  // sample pace
  // ----------------------------------------
  always_ff @(posedge clk_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pace_cnt <= '0;
      pace_stb <= 1'b0;
    end
    else if (!enable)
    begin
      pace_cnt <= '0;                      // restart on enable
      pace_stb <= 1'b0;
    end
    else if (pace_cnt == CNT_W'(CLK_DIV - 1))
    begin
      pace_cnt <= '0;
      pace_stb <= 1'b1;                    // terminal count
    end
    else
    begin
      pace_cnt <= pace_cnt + 1'b1;
      pace_stb <= 1'b0;
    end
  end

  // burst window, opened by full and closed by empty
  always_ff @(posedge clk_50M or negedge rst_n)
  begin
    if (!rst_n)
      burst <= 1'b0;
    else if (!enable)
      burst <= 1'b0;
    else if (fifo_full)
      burst <= 1'b1;                       // buffer ready
    else if (fifo_empty)
      burst <= 1'b0;                       // drained
  end

  assign pop = burst && pace_stb && !fifo_empty;  // one word per strobe

endmodule

// File: fir_coef_regs.sv
`timescale 1ns/10ps

module fir_coef_regs #(
  parameter int NUM_TAPS = 8
) (
  input  logic                           clk_50M,
  input  logic                           rst_n,
  input  logic                           coef_wr,    // single-cycle strobe
  input  logic [$clog2(NUM_TAPS)-1:0]    coef_addr,  // tap index
  input  audio_pkg::coef_t               coef_wdata,
  output audio_pkg::coef_t [NUM_TAPS-1:0] coef_bus   // all taps flattened
);

  import audio_pkg::*;

  coef_t [NUM_TAPS-1:0] coef_q;  // tap registers

  // ----------------------------------------
  // tap bank
  // ----------------------------------------
  always_ff @(posedge clk_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int k = 0; k < NUM_TAPS; k++)
      begin
        coef_q[k] <= (k == 0) ? COEF_UNITY : COEF_ZERO;  // pass-through
      end
    end
    else if (coef_wr)
    begin
      coef_q[coef_addr] <= coef_wdata;  // live next cycle
    end
  end

  assign coef_bus = coef_q;

endmodule

// File: fir_filter.sv
`timescale 1ns/10ps

module fir_filter #(
  parameter int NUM_TAPS = 8
) (
  input  logic                            clk_50M,
  input  logic                            rst_n,
  input  logic                            clear,       // flush delay line
  input  logic                            in_valid,
  input  audio_pkg::sample_t              in_sample,
  input  audio_pkg::coef_t [NUM_TAPS-1:0] coef_bus,
  output logic                            out_valid,   // in_valid + 2
  output audio_pkg::sample_t              out_sample
);

  import audio_pkg::*;

  localparam int PROD_W = SAMPLE_W + COEF_W;              // full product
  localparam logic signed [ACC_W-1:0] ROUND_BIAS = ACC_W'(2 ** (COEF_FRAC - 1));

  sample_t                  dly [NUM_TAPS];       // delay line
  sample_t                  tap_next [NUM_TAPS];  // line after this shift
  logic signed [PROD_W-1:0] prod_q [NUM_TAPS];    // stage 1
  logic signed [ACC_W-1:0]  acc_sum;
  logic signed [ACC_W-1:0]  acc_shr;
  sample_t                  sat;
  logic [1:0]               vld_sr;               // valid alongside data

  // ----------------------------------------
  // delay line
  // ----------------------------------------
  always_comb
  begin
    tap_next[0] = in_sample;              // newest sample at tap 0
    for (int k = 1; k < NUM_TAPS; k++)
    begin
      tap_next[k] = dly[k-1];
    end
  end

  always_ff @(posedge clk_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int k = 0; k < NUM_TAPS; k++)
        dly[k] <= '0;
    end
    else if (clear)
    begin
      for (int k = 0; k < NUM_TAPS; k++)
        dly[k] <= '0;                     // restart from silence
    end
    else if (in_valid)
    begin
      dly <= tap_next;                    // shift on each input
    end
  end

  // ----------------------------------------
  // stage 1, products
  // ----------------------------------------
  always_ff @(posedge clk_50M)
  begin
    if (in_valid)
    begin
      for (int k = 0; k < NUM_TAPS; k++)
      begin
        prod_q[k] <= PROD_W'(tap_next[k]) * PROD_W'($signed(coef_bus[k]));
      end
    end
  end

  // sum, round and rescale back from q1.15
  always_comb
  begin
    acc_sum = ROUND_BIAS;                 // half lsb for rounding
    for (int k = 0; k < NUM_TAPS; k++)
    begin
      acc_sum = acc_sum + ACC_W'(prod_q[k]);  // sign extended
    end
    acc_shr = acc_sum >>> COEF_FRAC;
    if (acc_shr > ACC_W'(SAMPLE_MAX))
      sat = SAMPLE_MAX;                   // clip high
    else if (acc_shr < ACC_W'(SAMPLE_MIN))
      sat = SAMPLE_MIN;                   // clip low
    else
      sat = sample_t'(acc_shr);
  end

  // ----------------------------------------
  // stage 2, result register
  // ----------------------------------------
  always_ff @(posedge clk_50M)
  begin
    if (vld_sr[0])
    begin
      out_sample <= sat;
    end
  end

  always_ff @(posedge clk_50M or negedge rst_n)
  begin
    if (!rst_n)
      vld_sr <= '0;
    else if (clear)
      vld_sr <= '0;                       // drop samples in flight
    else
      vld_sr <= {vld_sr[0], in_valid};
  end

  assign out_valid = vld_sr[1];

endmodule

// File: denoise_top.sv
`timescale 1ns/10ps

module denoise_top #(
  parameter int NUM_TAPS = 8,
  parameter int RX_DEPTH = 16,
  parameter int TX_DEPTH = 32,
  parameter int CLK_DIV  = 10
) (
  input  logic                        clk_50M,
  input  logic                        rst_n,
  input  logic                        enable,       // codec ready level
  input  logic                        rx_valid,     // capture strobe
  input  audio_pkg::sample_t          rx_data,
  input  logic                        tx_rd,        // sender pop
  input  logic                        coef_wr,
  input  logic [$clog2(NUM_TAPS)-1:0] coef_addr,
  input  audio_pkg::coef_t            coef_wdata,
  output logic                        fir_valid,
  output audio_pkg::sample_t          fir_out,
  output audio_pkg::sample_t          tx_data,
  output logic                        tx_empty,
  output logic                        tx_overflow   // sticky drop flag
);

  import audio_pkg::*;

  logic                 clear;     // datapath flush while disabled
  logic                 rx_full;
  logic                 rx_empty;
  logic                 rx_pop;    // also filter input strobe
  sample_t              rx_head;   // receive fifo head
  coef_t [NUM_TAPS-1:0] coef_bus;
  logic                 tx_full;

  assign clear = !enable;

  // ----------------------------------------
  // capture side
  // ----------------------------------------
  sample_fifo #(.DEPTH(RX_DEPTH)) i_rx_fifo (
    .clk_50M (clk_50M),
    .rst_n   (rst_n),
    .clear   (clear),
    .wr      (rx_valid),
    .wr_data (rx_data),
    .rd      (rx_pop),
    .rd_data (rx_head),
    .full    (rx_full),
    .empty   (rx_empty)
  );

  burst_read_ctrl #(.CLK_DIV(CLK_DIV)) i_burst_ctrl (
    .clk_50M    (clk_50M),
    .rst_n      (rst_n),
    .enable     (enable),
    .fifo_full  (rx_full),
    .fifo_empty (rx_empty),
    .pop        (rx_pop)
  );

  // ----------------------------------------
  // filter and its weights
  // ----------------------------------------
  fir_coef_regs #(.NUM_TAPS(NUM_TAPS)) i_coef_regs (
    .clk_50M    (clk_50M),
    .rst_n      (rst_n),
    .coef_wr    (coef_wr),
    .coef_addr  (coef_addr),
    .coef_wdata (coef_wdata),
    .coef_bus   (coef_bus)
  );

  fir_filter #(.NUM_TAPS(NUM_TAPS)) i_fir (
    .clk_50M    (clk_50M),
    .rst_n      (rst_n),
    .clear      (clear),
    .in_valid   (rx_pop),
    .in_sample  (rx_head),
    .coef_bus   (coef_bus),
    .out_valid  (fir_valid),
    .out_sample (fir_out)
  );

  // send side, no back-pressure into the filter
  sample_fifo #(.DEPTH(TX_DEPTH)) i_tx_fifo (
    .clk_50M (clk_50M),
    .rst_n   (rst_n),
    .clear   (clear),
    .wr      (fir_valid),
    .wr_data (fir_out),
    .rd      (tx_rd),
    .rd_data (tx_data),
    .full    (tx_full),
    .empty   (tx_empty)
  );

  always_ff @(posedge clk_50M or negedge rst_n)
  begin
    if (!rst_n)
      tx_overflow <= 1'b0;
    else if (!enable)
      tx_overflow <= 1'b0;                // cleared with the datapath
    else if (fir_valid && tx_full)
      tx_overflow <= 1'b1;                // result lost
  end

endmodule

// File: denoise_checker.sv
`timescale 1ns/10ps

module denoise_checker #(
  parameter int NUM_TAPS = 8,
  parameter int RX_DEPTH = 16,
  parameter int TX_DEPTH = 32,
  parameter int CLK_DIV  = 10
) (
  input  logic                        clk_50M,
  input  logic                        rst_n,
  input  logic                        enable,
  input  logic                        rx_valid,
  input  audio_pkg::sample_t          rx_data,
  input  logic                        tx_rd,
  input  logic                        coef_wr,
  input  logic [$clog2(NUM_TAPS)-1:0] coef_addr,
  input  audio_pkg::coef_t            coef_wdata,
  input  logic                        fir_valid,
  input  audio_pkg::sample_t          fir_out,
  input  audio_pkg::sample_t          tx_data,
  input  logic                        tx_empty,
  input  logic                        tx_overflow,
  output int                          err_cnt,     // mismatches so far
  output int                          chk_cnt,     // passing compares
  output int                          fir_total    // results seen, never cleared
);

  import audio_pkg::*;

  logic [NUM_TAPS-1:0][SAMPLE_W-1:0] hist;     // newest sample at index 0
  logic [NUM_TAPS-1:0][COEF_W-1:0]   coef_m;   // tap weights as written
  logic [SAMPLE_W-1:0]               exp_q [$]; // filter results still due
  logic [SAMPLE_W-1:0]               tx_q [$];  // transmit fifo contents
  logic                              ovf_m;    // sticky drop flag
  logic                              tx_full_m;
  logic [SAMPLE_W-1:0]               exp_w;
  int                                cyc;
  int                                wr_cnt;   // accepted writes since enable
  int                                out_cnt;  // results since enable
  int                                fill_cyc; // cycle of the write that filled rx
  int                                last_cyc;

  // ----------------------------------------
  // reference model of one filter output
  // ----------------------------------------
  function automatic logic [SAMPLE_W-1:0] fir_ref(
    input logic [NUM_TAPS-1:0][SAMPLE_W-1:0] win,
    input logic [NUM_TAPS-1:0][COEF_W-1:0]   cf
  );
    longint acc;
    acc = 0;
    for (int k = 0; k < NUM_TAPS; k++)
    begin
      acc = acc + longint'($signed(win[k])) * longint'($signed(cf[k]));  // exact product
    end
    acc = (acc + (longint'(1) <<< (COEF_FRAC - 1))) >>> COEF_FRAC;  // round half up
    if (acc > 32767)
      return 16'h7FFF;                      // clamp high
    if (acc < -32768)
      return 16'h8000;                      // clamp low
    return acc[SAMPLE_W-1:0];
  endfunction

  task automatic report_error(input string what);
    $display("error at cycle %0d: %s", cyc, what);
    err_cnt++;
  endtask

  task automatic compare_word(input string name, input logic [SAMPLE_W-1:0] exp,
                              input logic [SAMPLE_W-1:0] act);
    if (act !== exp)
    begin
      $display("[FAIL] %s expected 0x%h got 0x%h at cycle %0d", name, exp, act, cyc);
      err_cnt++;
    end
    else
      chk_cnt++;
  endtask

  // ----------------------------------------
  // compare on the falling edge, inputs and outputs both settled
  // ----------------------------------------
  always @(negedge clk_50M)
  begin
    cyc++;
    if (!rst_n)
    begin
      hist      = '0;
      coef_m    = '0;
      coef_m[0] = COEF_UNITY;               // pass-through weights
      exp_q.delete();
      tx_q.delete();
      ovf_m     = 1'b0;
      wr_cnt    = 0;
      out_cnt   = 0;
      fill_cyc  = 0;
      last_cyc  = 0;
      err_cnt   = 0;
      chk_cnt   = 0;
      fir_total = 0;
    end
    else
    begin
      compare_word("tx_empty", 16'(tx_q.size() == 0), 16'(tx_empty));
      compare_word("tx_overflow", 16'(ovf_m), 16'(tx_overflow));
      tx_full_m = (tx_q.size() >= TX_DEPTH);  // level before this edge
      if (enable && tx_rd && tx_q.size() > 0)
      begin
        exp_w = tx_q.pop_front();
        compare_word("tx_data", exp_w, tx_data);
      end
      if (fir_valid)
      begin
        if (exp_q.size() == 0)
          report_error("fir_valid pulse with no result pending");
        else
        begin
          exp_w = exp_q.pop_front();
          compare_word("fir_out", exp_w, fir_out);
          if (wr_cnt < RX_DEPTH * (out_cnt / RX_DEPTH + 1))
            report_error("fir_valid came before the receive FIFO filled");
          if (out_cnt % RX_DEPTH == 0)
          begin
            if (cyc - fill_cyc < 3 || cyc - fill_cyc > CLK_DIV + 3)
              report_error($sformatf("first result of a burst came %0d cycles after the fill",
                                     cyc - fill_cyc));
          end
          else if (cyc - last_cyc != CLK_DIV)
            report_error($sformatf("results came %0d cycles apart instead of %0d",
                                   cyc - last_cyc, CLK_DIV));
          last_cyc = cyc;
          if (enable && tx_full_m)
            ovf_m = 1'b1;                   // result dropped
          else if (enable)
            tx_q.push_back(exp_w);
        end
        out_cnt++;
        fir_total++;
      end
      if (coef_wr && int'(coef_addr) < NUM_TAPS)
        coef_m[coef_addr] = coef_wdata;
      if (enable && rx_valid && (wr_cnt - out_cnt) < RX_DEPTH)
      begin
        hist = {hist[NUM_TAPS-2:0], rx_data};  // shift in newest
        exp_q.push_back(fir_ref(hist, coef_m));
        wr_cnt++;
        if (wr_cnt % RX_DEPTH == 0)
          fill_cyc = cyc;                   // rx fifo full after this write
      end
      if (!enable)
      begin
        hist    = '0;                       // datapath flushed
        exp_q.delete();
        tx_q.delete();
        ovf_m   = 1'b0;
        wr_cnt  = 0;
        out_cnt = 0;
      end
    end
  end

endmodule

// File: tb_denoise.sv
`timescale 1ns/10ps

module tb_denoise;

  import audio_pkg::*;

  localparam int NUM_TAPS = 8;
  localparam int RX_DEPTH = 16;
  localparam int TX_DEPTH = 32;
  localparam int CLK_DIV  = 10;
  localparam int ADDR_W   = $clog2(NUM_TAPS);

  // ----------------------------------------
  // run length bound
  // ----------------------------------------
  localparam int BURST_CYC   = RX_DEPTH + (RX_DEPTH + 4) * CLK_DIV;  // fill, drain, tail
  localparam int NUM_BURSTS  = 8;                                   // over all tests
  localparam int TIMEOUT_CYC = 2 * (NUM_BURSTS * BURST_CYC + 2 * TX_DEPTH
                                    + 20 * NUM_TAPS + 100);

  logic              clk_50M = 1'b0;
  logic              rst_n;
  logic              enable;
  logic              rx_valid;
  sample_t           rx_data;
  logic              tx_rd;
  logic              coef_wr;
  logic [ADDR_W-1:0] coef_addr;
  coef_t             coef_wdata;
  logic              fir_valid;
  sample_t           fir_out;
  sample_t           tx_data;
  logic              tx_empty;
  logic              tx_overflow;
  int                err_cnt;
  int                chk_cnt;
  int                fir_total;
  int                seed = 32'h001b_a47d;  // fixed stimulus seed
  int                cyc  = 0;
  int                tests_ok;
  int                tests_bad;
  int                err_mark;              // errors before the current test

  always #10 clk_50M = ~clk_50M;            // 50 MHz

  denoise_top #(
    .NUM_TAPS (NUM_TAPS),
    .RX_DEPTH (RX_DEPTH),
    .TX_DEPTH (TX_DEPTH),
    .CLK_DIV  (CLK_DIV)
  ) i_dut (
    .clk_50M     (clk_50M),
    .rst_n       (rst_n),
    .enable      (enable),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .tx_rd       (tx_rd),
    .coef_wr     (coef_wr),
    .coef_addr   (coef_addr),
    .coef_wdata  (coef_wdata),
    .fir_valid   (fir_valid),
    .fir_out     (fir_out),
    .tx_data     (tx_data),
    .tx_empty    (tx_empty),
    .tx_overflow (tx_overflow)
  );

  denoise_checker #(
    .NUM_TAPS (NUM_TAPS),
    .RX_DEPTH (RX_DEPTH),
    .TX_DEPTH (TX_DEPTH),
    .CLK_DIV  (CLK_DIV)
  ) i_checker (
    .clk_50M     (clk_50M),
    .rst_n       (rst_n),
    .enable      (enable),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .tx_rd       (tx_rd),
    .coef_wr     (coef_wr),
    .coef_addr   (coef_addr),
    .coef_wdata  (coef_wdata),
    .fir_valid   (fir_valid),
    .fir_out     (fir_out),
    .tx_data     (tx_data),
    .tx_empty    (tx_empty),
    .tx_overflow (tx_overflow),
    .err_cnt     (err_cnt),
    .chk_cnt     (chk_cnt),
    .fir_total   (fir_total)
  );

  always @(posedge clk_50M)
  begin
    cyc++;
    if (cyc >= TIMEOUT_CYC)
    begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYC);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // stimulus helpers, all drive 2 ns after the edge
  // ----------------------------------------
  task automatic tick();
    @(posedge clk_50M);
    #2;
  endtask

  task automatic write_coef(input int addr, input coef_t val);
    coef_wr    = 1'b1;
    coef_addr  = ADDR_W'(addr);
    coef_wdata = val;
    tick();
    coef_wr    = 1'b0;
  endtask

  task automatic load_random_coefs();
    for (int k = 0; k < NUM_TAPS; k++)
      write_coef(k, $signed(16'($random(seed))) >>> 3);  // keep most sums in range
  endtask

  task automatic set_enable(input logic level);
    enable = level;
    repeat (2) tick();
  endtask

  // fill the rx fifo once and wait for every result of the burst
  task automatic run_burst(input bit saturate);
    int target;
    target = fir_total + RX_DEPTH;
    for (int i = 0; i < RX_DEPTH; i++)
    begin
      rx_valid = 1'b1;
      if (saturate)
        rx_data = (i < RX_DEPTH / 2) ? SAMPLE_MAX : SAMPLE_MIN;  // full scale both ways
      else
        rx_data = sample_t'($random(seed));
      tick();
    end
    rx_valid = 1'b0;
    while (fir_total < target)
      tick();
    repeat (3 * CLK_DIV) tick();           // room for stray pulses
  endtask

  task automatic drain_tx();
    tick();
    while (!tx_empty)
    begin
      tx_rd = 1'b1;                         // back-to-back pops
      tick();
    end
    tx_rd = 1'b0;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == err_mark)
    begin
      $display("test %s: passed", name);
      tests_ok++;
    end
    else
    begin
      $display("test %s: failed with %0d errors", name, err_cnt - err_mark);
      tests_bad++;
    end
    err_mark = err_cnt;
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial
  begin
    rst_n      = 1'b0;
    enable     = 1'b0;
    rx_valid   = 1'b0;
    rx_data    = '0;
    tx_rd      = 1'b0;
    coef_wr    = 1'b0;
    coef_addr  = '0;
    coef_wdata = '0;
    tests_ok   = 0;
    tests_bad  = 0;
    err_mark   = 0;
    repeat (5) @(posedge clk_50M);
    #2;
    rst_n = 1'b1;

    repeat (2 * CLK_DIV) tick();           // idle, disabled
    end_test("reset state");

    set_enable(1'b1);
    run_burst(1'b0);
    end_test("default pass-through");

    set_enable(1'b0);                       // weights change only while disabled
    load_random_coefs();
    set_enable(1'b1);
    run_burst(1'b0);
    run_burst(1'b0);                        // history spans the boundary
    end_test("programmed low-pass");

    set_enable(1'b0);
    for (int k = 0; k < NUM_TAPS; k++)
      write_coef(k, 16'sh4000);             // half on every tap
    set_enable(1'b1);
    run_burst(1'b1);
    end_test("saturation");

    set_enable(1'b0);
    load_random_coefs();
    set_enable(1'b1);
    run_burst(1'b0);
    drain_tx();
    end_test("transmit order");

    repeat (3) run_burst(1'b0);             // more than TX_DEPTH results
    drain_tx();
    set_enable(1'b0);                       // drop flag clears here
    end_test("transmit overflow");

    $display("tests passed %0d failed %0d, compares %0d, errors %0d",
             tests_ok, tests_bad, chk_cnt, err_cnt);
    if (tests_bad == 0 && err_cnt == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: sources.f
audio_pkg.sv
sample_fifo.sv
burst_read_ctrl.sv
fir_coef_regs.sv
fir_filter.sv
denoise_top.sv
denoise_checker.sv
tb_denoise.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the denoise testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_denoise -f sources.f -o sim_denoise
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_denoise > "$LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"
if grep -q "^TEST PASS$" "$LOG"; then
  exit 0
else
  exit 1
fi
